//--- dv/jag_mem_props.sv
module jag_mem_props (
	input logic clk_sys,
	input logic reset,
	input logic ioctl_download,
	input logic ddr_busy,
	input logic ddr_rd,
	input logic ddr_we,
	input logic ddr_dout_ready,
	input logic cart_wait_n
);

	int unsigned fail_count = 0; // Failed assertion count

	// ====================
	// DDR port
	// ====================
	rd_we_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(ddr_rd && ddr_we))
		else begin
			fail_count++;
			$error("ddr_rd and ddr_we high in the same cycle");
		end

	no_issue_when_busy: assert property (@(posedge clk_sys) disable iff (reset)
		ddr_busy |-> !(ddr_rd || ddr_we))
		else begin
			fail_count++;
			$error("DDR request issued while ddr_busy was high");
		end

	we_only_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		ddr_we |-> ioctl_download)
		else begin
			fail_count++;
			$error("ddr_we high outside a host download");
		end

	// Console wait held until the read data arrives
	wait_held_to_data: assert property (@(posedge clk_sys) disable iff (reset)
		!cart_wait_n |=> (!cart_wait_n || ddr_dout_ready))
		else begin
			fail_count++;
			$error("cart_wait_n released before ddr_dout_ready");
		end

endmodule

bind jag_mem_top jag_mem_props u_props (
	.clk_sys        (clk_sys),
	.reset          (reset),
	.ioctl_download (ioctl_download),
	.ddr_busy       (ddr_busy),
	.ddr_rd         (ddr_rd),
	.ddr_we         (ddr_we),
	.ddr_dout_ready (ddr_dout_ready),
	.cart_wait_n    (cart_wait_n)
);

//--- dv/tb_jag_mem.sv
module tb_jag_mem;
	import jag_mem_pkg::*;

	localparam logic [7:0] REGION     = 8'h30;
	localparam int         LOAD_WORDS = 32;
	localparam int         BIOS_WORDS = 16;
	localparam int         PRIO_WORDS = 16;
	localparam bios_addr_t BIOS_BASE  = PATCH_ADDR - bios_addr_t'(16); // Patch byte inside
	localparam abus_t      PRIO_ADDR  = CART_LOAD_BASE + abus_t'(24'h14);
	// Download words, cart reads and BIOS byte reads
	localparam int TOTAL_WORDS    = LOAD_WORDS * 2 + BIOS_WORDS * 3 + PRIO_WORDS + 4;
	localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 20 + 200;

	logic        clk_sys;
	logic        reset;
	logic        ioctl_download;
	logic        ioctl_wr;
	ioctl_index_t ioctl_index;
	ioctl_addr_t ioctl_addr;
	ioctl_data_t ioctl_data;
	logic        ioctl_wait;
	abus_t       abus;
	logic        cart_ce_n;
	cart_data_t  cart_q;
	logic        cart_wait_n;
	logic        checksum_patch;
	bios_data_t  bios_q;
	logic        ddr_busy;
	ddr_addr_t   ddr_addr;
	ddr_data_t   ddr_din;
	ddr_be_t     ddr_be;
	logic        ddr_rd;
	logic        ddr_we;
	ddr_data_t   ddr_dout;
	logic        ddr_dout_ready;

	logic [31:0] lfsr_state = 32'h663d750b;
	ddr_data_t   mem_model [ddr_addr_t]; // DDR contents by beat address
	ioctl_data_t exp_words [$];          // Sent, not yet seen on the DDR port
	ioctl_data_t load_data [LOAD_WORDS];
	ioctl_data_t prio_data [PRIO_WORDS];
	ioctl_data_t bios_words [BIOS_WORDS];
	int          wr_index = 0;           // Writes seen in this download
	int          rd_total = 0;
	int          rd_mark = 0;            // rd_total at the start of a read
	int          mismatches = 0;
	int          other_errors = 0;
	logic        rd_pending = 1'b0;
	int          rd_delay = 0;
	ddr_addr_t   rd_addr_q;
	ioctl_data_t mon_word;
	abus_t       mon_addr;
	ddr_data_t   mon_beat;
	string       test_name = "reset";

	jag_mem_top #(
		.DDR_REGION (REGION)
	) dut (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.ioctl_wait     (ioctl_wait),
		.abus           (abus),
		.cart_ce_n      (cart_ce_n),
		.cart_q         (cart_q),
		.cart_wait_n    (cart_wait_n),
		.checksum_patch (checksum_patch),
		.bios_q         (bios_q),
		.ddr_busy       (ddr_busy),
		.ddr_addr       (ddr_addr),
		.ddr_din        (ddr_din),
		.ddr_be         (ddr_be),
		.ddr_rd         (ddr_rd),
		.ddr_we         (ddr_we),
		.ddr_dout       (ddr_dout),
		.ddr_dout_ready (ddr_dout_ready)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ====================
	// Random source
	// ====================
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // Taps 32,22,2,1
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]}; // One step per bit
		end
		return v;
	endfunction

	// ====================
	// Reference model
	// ====================
	function automatic ddr_be_t exp_be(input abus_t a);
		return ddr_be_t'(8'hC0 >> (2 * a[2:1])); // Word 0 on the top lane pair
	endfunction

	function automatic ddr_data_t exp_beat(input ioctl_data_t w);
		return {4{w[7:0], w[15:8]}};
	endfunction

	function automatic cart_data_t exp_cart(input ddr_data_t beat, input abus_t a);
		return a[2] ? beat[31:0] : beat[63:32];
	endfunction

	function automatic bios_data_t exp_bios(input bios_addr_t a, input logic patch);
		ioctl_data_t w;
		w = bios_words[int'((a - BIOS_BASE) >> 1)];
		if (patch && a == PATCH_ADDR)
			return PATCH_OPCODE;
		return a[0] ? w[15:8] : w[7:0]; // Low byte at the even address
	endfunction

	function automatic ddr_data_t model_beat(input ddr_addr_t a);
		if (mem_model.exists(a))
			return mem_model[a];
		return {3'b000, a, 3'b000, ~a}; // Never written
	endfunction

	// ====================
	// Compare tasks
	// ====================
	task automatic report_error(input string msg);
		other_errors++;
		$display("Error: %s", msg);
	endtask

	task automatic check_addr(input string name, input ddr_addr_t exp, input ddr_addr_t act);
		if (act !== exp) begin
			mismatches++;
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_be(input string name, input ddr_be_t exp, input ddr_be_t act);
		if (act !== exp) begin
			mismatches++;
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_beat(input string name, input ddr_data_t exp, input ddr_data_t act);
		if (act !== exp) begin
			mismatches++;
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_cart(input string name, input cart_data_t exp, input cart_data_t act);
		if (act !== exp) begin
			mismatches++;
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_bios(input string name, input bios_data_t exp, input bios_data_t act);
		if (act !== exp) begin
			mismatches++;
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// ====================
	// DDR model
	// ====================
	// Busy and read data change just after the edge
	initial begin
		ddr_busy       = 1'b0;
		ddr_dout       = '0;
		ddr_dout_ready = 1'b0;
		forever begin
			@(posedge clk_sys);
			#1;
			ddr_dout_ready = 1'b0;
			if (rd_pending) begin
				if (rd_delay == 0) begin
					ddr_dout       = model_beat(rd_addr_q);
					ddr_dout_ready = 1'b1;
					rd_pending     = 1'b0;
				end else begin
					rd_delay--;
				end
			end
			ddr_busy = (rand_bits(2) == 32'd3); // Busy about one cycle in four
		end
	end

	// Port monitor and compare, mid-cycle where all strobes are settled
	always @(negedge clk_sys) begin
		if (ioctl_wr && ioctl_wait)
			report_error("host strobe sent while ioctl_wait was high");
		if (ddr_we) begin
			if (exp_words.size() == 0) begin
				report_error("DDR write with no host word pending");
			end else begin
				mon_word = exp_words.pop_front();
				mon_addr = CART_LOAD_BASE + abus_t'(2 * wr_index);
				check_addr($sformatf("%s word %0d addr", test_name, wr_index),
					{REGION, mon_addr[23:3]}, ddr_addr);
				check_be($sformatf("%s word %0d be", test_name, wr_index),
					exp_be(mon_addr), ddr_be);
				check_beat($sformatf("%s word %0d din", test_name, wr_index),
					exp_beat(mon_word), ddr_din);
				wr_index++;
			end
			mon_beat = model_beat(ddr_addr);
			for (int i = 0; i < 8; i++) begin
				if (ddr_be[i])
					mon_beat[8*i +: 8] = ddr_din[8*i +: 8]; // Lane merge
			end
			mem_model[ddr_addr] = mon_beat;
		end
		if (ddr_rd) begin
			rd_total++;
			if (ioctl_download)
				report_error("DDR read issued while a download was active");
			check_addr({test_name, " read addr"}, {REGION, abus[23:3]}, ddr_addr);
			check_be({test_name, " read be"}, 8'hFF, ddr_be);
			rd_addr_q  = ddr_addr;
			rd_delay   = int'(rand_bits(3) % 6); // Latency 1 to 6
			rd_pending = 1'b1;
		end
	end

	// ====================
	// Stimulus tasks
	// ====================
	task automatic start_load();
		@(posedge clk_sys);
		#1;
		ioctl_index    = ioctl_index_t'(ROM_SLOT);
		ioctl_download = 1'b1;
		wr_index       = 0;
		exp_words.delete();
	endtask

	task automatic send_load_word(input ioctl_data_t w);
		@(posedge clk_sys);
		#1;
		ioctl_wr   = 1'b1;
		ioctl_data = w;
		ioctl_addr = ioctl_addr_t'(2 * (wr_index + exp_words.size()));
		exp_words.push_back(w);
		@(posedge clk_sys);
		#1;
		ioctl_wr = 1'b0;
		@(negedge clk_sys);
		if (ioctl_wait !== 1'b1)
			report_error($sformatf("%s: ioctl_wait did not rise after a strobe", test_name));
		while (ioctl_wait)
			@(negedge clk_sys);
	endtask

	task automatic end_load();
		@(posedge clk_sys);
		#1;
		ioctl_download = 1'b0;
	endtask

	task automatic check_word_count(input int n);
		if (wr_index != n || exp_words.size() != 0)
			report_error($sformatf("%s: %0d of %0d words reached the DDR",
				test_name, wr_index, n));
	endtask

	task automatic start_cart_read(input abus_t a);
		@(posedge clk_sys);
		#1;
		abus      = a;
		cart_ce_n = 1'b0;
		rd_mark   = rd_total;
		@(posedge clk_sys); // Past the trigger cycle
	endtask

	task automatic finish_cart_read(input abus_t a);
		ddr_data_t beat;
		@(negedge clk_sys);
		while (!ddr_dout_ready) begin
			if (cart_wait_n !== 1'b0)
				report_error($sformatf("%s: cart_wait_n high during read of %h", test_name, a));
			@(negedge clk_sys);
		end
		if (cart_wait_n !== 1'b1)
			report_error($sformatf("%s: cart_wait_n not released with data for %h",
				test_name, a));
		beat = model_beat({REGION, a[23:3]});
		check_cart($sformatf("%s addr %h", test_name, a), exp_cart(beat, a), cart_q);
		if (rd_total - rd_mark != 1)
			report_error($sformatf("%s: %0d DDR reads for one access at %h",
				test_name, rd_total - rd_mark, a));
	endtask

	task automatic send_bios_word(input int k);
		@(posedge clk_sys);
		#1;
		ioctl_wr   = 1'b1;
		ioctl_addr = ioctl_addr_t'(BIOS_BASE) + ioctl_addr_t'(2 * k);
		ioctl_data = bios_words[k];
		@(posedge clk_sys);
		#1;
		ioctl_wr = 1'b0;
		repeat (2) @(posedge clk_sys); // Low then high byte write
	endtask

	task automatic bios_read(input bios_addr_t a, input logic patch);
		@(posedge clk_sys);
		#1;
		abus           = abus_t'(a);
		checksum_patch = patch;
		@(posedge clk_sys);
		@(negedge clk_sys); // One cycle of read latency
		check_bios($sformatf("%s addr %h patch %0b", test_name, a, patch),
			exp_bios(a, patch), bios_q);
	endtask

	// ====================
	// Watchdog
	// ====================
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk_sys);
		$display("Timeout after %0d cycles in test %s, a handshake never completed",
			TIMEOUT_CYCLES, test_name);
		$display("Testbench failed");
		$finish;
	end

	// ====================
	// Test sequence
	// ====================
	initial begin
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_data     = '0;
		abus           = '0;
		cart_ce_n      = 1'b1;
		checksum_patch = 1'b0;
		for (int k = 0; k < LOAD_WORDS; k++)
			load_data[k] = ioctl_data_t'(rand_bits(16));
		for (int k = 0; k < PRIO_WORDS; k++)
			prio_data[k] = ioctl_data_t'(rand_bits(16));
		for (int k = 0; k < BIOS_WORDS; k++)
			bios_words[k] = ioctl_data_t'(rand_bits(16));
		bios_words[(PATCH_ADDR - BIOS_BASE) >> 1][7:0] = 8'h67; // BEQ at the branch
		repeat (2) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		@(negedge clk_sys);
		if (ioctl_wait !== 1'b0)
			report_error("ioctl_wait not low after reset");
		if (ddr_rd !== 1'b0 || ddr_we !== 1'b0)
			report_error("DDR strobe active after reset");
		if (cart_wait_n !== 1'b1)
			report_error("cart_wait_n not high after reset");

		test_name = "cart_load";
		start_load();
		for (int k = 0; k < LOAD_WORDS; k++)
			send_load_word(load_data[k]);
		end_load();
		check_word_count(LOAD_WORDS);

		test_name = "cart_read"; // Two longwords per beat
		for (int k = 0; k < LOAD_WORDS / 2; k++) begin
			start_cart_read(CART_LOAD_BASE + abus_t'(4 * k));
			finish_cart_read(CART_LOAD_BASE + abus_t'(4 * k));
		end
		@(posedge clk_sys);
		#1;
		cart_ce_n = 1'b1;

		test_name = "bios_load";
		@(posedge clk_sys);
		#1;
		ioctl_index    = ioctl_index_t'(BIOS_SLOT_B);
		ioctl_download = 1'b1;
		for (int k = 0; k < BIOS_WORDS; k++)
			send_bios_word(k);
		end_load();
		test_name = "bios_read";
		for (int k = 0; k < BIOS_WORDS * 2; k++)
			bios_read(BIOS_BASE + bios_addr_t'(k), 1'b0);

		test_name = "checksum_patch";
		bios_read(PATCH_ADDR, 1'b0);
		bios_read(PATCH_ADDR, 1'b1);

		// Read raised halfway through a download, held off until it ends
		test_name = "loader_priority";
		start_load();
		for (int k = 0; k < PRIO_WORDS / 2; k++)
			send_load_word(prio_data[k]);
		start_cart_read(PRIO_ADDR);
		for (int k = PRIO_WORDS / 2; k < PRIO_WORDS; k++)
			send_load_word(prio_data[k]);
		end_load();
		finish_cart_read(PRIO_ADDR);
		check_word_count(PRIO_WORDS);

		repeat (2) @(posedge clk_sys);
		$display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatches, other_errors, dut.u_props.fail_count);
		if (mismatches == 0 && other_errors == 0 && dut.u_props.fail_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- flist.f
src/jag_mem_pkg.sv
src/ddr_req_if.sv
src/cart_loader.sv
src/cart_reader.sv
src/ddr_arbiter.sv
src/bios_store.sv
src/jag_mem_top.sv
dv/jag_mem_props.sv
dv/tb_jag_mem.sv

//--- src/bios_store.sv
module bios_store (
	input  logic                      clk_sys,
	input  logic                      ioctl_download,
	input  logic                      ioctl_wr,
	input  jag_mem_pkg::ioctl_index_t ioctl_index,
	input  jag_mem_pkg::ioctl_addr_t  ioctl_addr,
	input  jag_mem_pkg::ioctl_data_t  ioctl_data,
	input  jag_mem_pkg::abus_t        abus,
	input  logic                      checksum_patch,
	output jag_mem_pkg::bios_data_t   bios_q
);
	import jag_mem_pkg::*;

	bios_data_t  mem [0:(2 ** $bits(bios_addr_t)) - 1]; // 128 KiB byte array

	logic        bios_index;
	logic        bios_stb;
	logic        wr_lo = 1'b0; // Low byte write cycle
	logic        wr_hi = 1'b0; // High byte write cycle
	logic [15:0] word_addr;    // Host word address
	ioctl_data_t word_q;
	bios_addr_t  wr_addr;
	bios_data_t  wr_data;
	bios_addr_t  rd_addr;
	bios_data_t  rd_q;
	logic        patch_hit;

	assign bios_index = (ioctl_index[5:0] == BIOS_SLOT_A) ||
		(ioctl_index[5:0] == BIOS_SLOT_B);
	assign bios_stb = ioctl_download && ioctl_wr && bios_index;

	// ====================
	// Download side
	// ====================
	// Each host word becomes two byte writes on consecutive cycles
	always_ff @(posedge clk_sys) begin
		wr_lo <= bios_stb;
		wr_hi <= wr_lo;
	end

	always_ff @(posedge clk_sys) begin
		if (bios_stb) begin
			word_q    <= ioctl_data;
			word_addr <= ioctl_addr[16:1];
		end
	end

	assign wr_addr = {word_addr, wr_hi};                      // Even then odd
	assign wr_data = wr_hi ? word_q[15:8] : word_q[7:0];

	always_ff @(posedge clk_sys) begin
		if (wr_lo || wr_hi)
			mem[wr_addr] <= wr_data;
	end

	// ====================
	// Console side
	// ====================
	assign rd_addr = abus[16:0];

	always_ff @(posedge clk_sys) begin
		rd_q      <= mem[rd_addr];
		patch_hit <= checksum_patch && (rd_addr == PATCH_ADDR); // Same cycle as the read
	end

	// BEQ becomes BRA so a bad cart checksum is skipped
	assign bios_q = patch_hit ? PATCH_OPCODE : rd_q;

endmodule

//--- src/cart_loader.sv
module cart_loader (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      ioctl_download,
	input  logic                      ioctl_wr,
	input  jag_mem_pkg::ioctl_index_t ioctl_index,
	input  jag_mem_pkg::ioctl_data_t  ioctl_data,
	output logic                      ioctl_wait,
	output logic                      loading,
	ddr_req_if.requester              req_bus
);
	import jag_mem_pkg::*;

	logic        old_download; // Download edge detect
	logic        rom_index;
	logic        load_stb;     // Host word for the cart slot
	logic        wr_req;
	abus_t       load_addr;    // Byte address of the pending word
	ioctl_data_t word_q;
	ioctl_data_t word_bs;      // Byte-swapped word
	ddr_be_t     lane_be;

	assign rom_index = (ioctl_index[5:0] == ROM_SLOT);
	assign load_stb  = ioctl_wr && ioctl_download && rom_index;

	// ====================
	// Control
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			loading      <= 1'b0;
			ioctl_wait   <= 1'b0;
			wr_req       <= 1'b0;
			load_addr    <= CART_LOAD_BASE;
		end else begin
			old_download <= ioctl_download;
			if (!old_download && ioctl_download && rom_index) begin
				load_addr <= CART_LOAD_BASE; // New cart starts at the window base
				loading   <= 1'b1;
				ioctl_wait <= 1'b0;
			end
			if (wr_req && req_bus.ack) begin
				wr_req     <= 1'b0;
				ioctl_wait <= 1'b0;                    // Host may send the next word
				load_addr  <= load_addr + abus_t'(2); // One 16-bit word per write
			end
			if (load_stb) begin
				wr_req     <= 1'b1;
				ioctl_wait <= 1'b1; // Hold the host until the DDR takes it
			end
			if (old_download && !ioctl_download) begin
				loading    <= 1'b0;
				ioctl_wait <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (load_stb)
			word_q <= ioctl_data;
	end

	// Host words arrive little-endian, the console bus is big-endian
	assign word_bs = {word_q[7:0], word_q[15:8]};

	// Lane pair from the word position in the beat
	always_comb begin
		case (load_addr[2:1])
			2'd0:    lane_be = 8'b1100_0000;
			2'd1:    lane_be = 8'b0011_0000;
			2'd2:    lane_be = 8'b0000_1100;
			default: lane_be = 8'b0000_0011;
		endcase
	end

	assign req_bus.req  = wr_req;
	assign req_bus.we   = 1'b1;
	assign req_bus.addr = load_addr;
	assign req_bus.din  = {4{word_bs}}; // Same word on every lane
	assign req_bus.be   = lane_be;

endmodule

//--- src/cart_reader.sv
module cart_reader (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  jag_mem_pkg::abus_t      abus,
	input  logic                    cart_ce_n,
	input  jag_mem_pkg::ddr_data_t  ddr_dout,
	input  logic                    ddr_dout_ready,
	output jag_mem_pkg::cart_data_t cart_q,
	output logic                    cart_wait_n,
	ddr_req_if.requester            req_bus
);
	import jag_mem_pkg::*;

	rd_state_e  rd_state;
	abus_t      old_abus;  // Last cycle's address
	abus_t      rd_addr;   // Address of the read in flight
	logic       old_ce_n;
	logic       rd_trig;
	logic       rd_done;   // Data beat for our read
	cart_data_t beat_half;
	cart_data_t q_hold;

	// New access on a chip enable fall or address change
	assign rd_trig = !cart_ce_n && ((old_ce_n && !cart_ce_n) || (abus != old_abus));
	assign rd_done = (rd_state == RD_WAIT) && ddr_dout_ready;

	// ====================
	// Read FSM
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_state <= RD_IDLE;
			old_ce_n <= 1'b1;
			old_abus <= '1;
		end else begin
			old_ce_n <= cart_ce_n;
			old_abus <= abus;
			case (rd_state)
				RD_IDLE:  if (rd_trig) rd_state <= RD_ISSUE;
				RD_ISSUE: if (req_bus.ack) rd_state <= RD_WAIT; // ddr_rd went out
				RD_WAIT:  if (ddr_dout_ready) rd_state <= RD_IDLE;
				default:  rd_state <= RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rd_state == RD_IDLE && rd_trig)
			rd_addr <= abus;
		if (rd_done)
			q_hold <= beat_half; // Kept for the core after wait ends
	end

	// Even longword sits in the upper half of the beat
	assign beat_half = rd_addr[2] ? ddr_dout[31:0] : ddr_dout[63:32];

	assign cart_q      = rd_done ? beat_half : q_hold;
	assign cart_wait_n = (rd_state == RD_IDLE) || rd_done; // Released in the data cycle

	assign req_bus.req  = (rd_state == RD_ISSUE);
	assign req_bus.we   = 1'b0;
	assign req_bus.addr = rd_addr;
	assign req_bus.din  = '0;
	assign req_bus.be   = '1;

endmodule

//--- src/ddr_arbiter.sv
module ddr_arbiter #(
	parameter logic [7:0] DDR_REGION = 8'h30 // Upper DDR word address bits
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   loading,
	input  logic                   ddr_busy,
	ddr_req_if.arbiter             loader_bus,
	ddr_req_if.arbiter             reader_bus,
	output jag_mem_pkg::ddr_addr_t ddr_addr,
	output jag_mem_pkg::ddr_data_t ddr_din,
	output jag_mem_pkg::ddr_be_t   ddr_be,
	output logic                   ddr_rd,
	output logic                   ddr_we
);
	import jag_mem_pkg::*;

	grant_e    owner;
	logic      loading_q; // Download flag one cycle late
	logic      reader_ok;
	logic      issue;     // Winner goes out this cycle
	logic      sel_we;
	abus_t     sel_addr;
	ddr_data_t sel_din;
	ddr_be_t   sel_be;

	always_ff @(posedge clk_sys) begin
		if (reset)
			loading_q <= 1'b0;
		else
			loading_q <= loading;
	end

	// Reads stay off the port for a cycle after a download closes
	assign reader_ok = !loading && !loading_q;

	// ====================
	// Grant
	// ====================
	always_comb begin
		if (loader_bus.req)
			owner = GNT_LOADER; // Download always wins
		else if (reader_bus.req && reader_ok)
			owner = GNT_READER;
		else
			owner = GNT_NONE;
	end

	always_comb begin
		if (owner == GNT_LOADER) begin
			sel_we   = loader_bus.we;
			sel_addr = loader_bus.addr;
			sel_din  = loader_bus.din;
			sel_be   = loader_bus.be;
		end else begin
			sel_we   = reader_bus.we;
			sel_addr = reader_bus.addr;
			sel_din  = reader_bus.din;
			sel_be   = reader_bus.be;
		end
	end

	assign issue = (owner != GNT_NONE) && !ddr_busy;

	// Byte address to beat address inside the console region
	assign ddr_addr = {DDR_REGION, sel_addr[23:3]};
	assign ddr_din  = sel_din;
	assign ddr_be   = sel_we ? sel_be : '1; // Controller wants all lanes on reads
	assign ddr_we   = issue && sel_we;
	assign ddr_rd   = issue && !sel_we;

	assign loader_bus.ack = issue && (owner == GNT_LOADER);
	assign reader_bus.ack = issue && (owner == GNT_READER);

endmodule

//--- src/ddr_req_if.sv
interface ddr_req_if;
	import jag_mem_pkg::*;

	// Request side, held steady until ack
	logic      req;  // Request pending
	logic      we;   // 1 write, 0 read
	abus_t     addr; // Byte address, bits 2..0 dropped at the port
	ddr_data_t din;  // Write beat
	ddr_be_t   be;   // Write lanes

	// Taken this cycle
	logic      ack;

	modport requester (
		output req,
		output we,
		output addr,
		output din,
		output be,
		input  ack
	);

	modport arbiter (
		input  req,
		input  we,
		input  addr,
		input  din,
		input  be,
		output ack
	);

endinterface

//--- src/jag_mem_pkg.sv
package jag_mem_pkg;

	// ====================
	// Bus types
	// ====================
	typedef logic [28:0] ddr_addr_t;    // DDR word address, 64-bit beats
	typedef logic [63:0] ddr_data_t;    // One DDR beat
	typedef logic [7:0]  ddr_be_t;      // Bit 7 enables the top byte
	typedef logic [23:0] abus_t;        // Console byte address
	typedef logic [31:0] cart_data_t;   // 32-bit cartridge word
	typedef logic [24:0] ioctl_addr_t;  // Host download byte address
	typedef logic [15:0] ioctl_data_t;  // Host download word
	typedef logic [7:0]  ioctl_index_t; // Slot number, low 6 bits used
	typedef logic [16:0] bios_addr_t;   // 128 KiB BIOS
	typedef logic [7:0]  bios_data_t;

	// ====================
	// Memory map
	// ====================
	// Download slots, compared against ioctl_index[5:0]
	localparam logic [5:0] ROM_SLOT    = 6'd1;
	localparam logic [5:0] BIOS_SLOT_A = 6'd0;
	localparam logic [5:0] BIOS_SLOT_B = 6'd2;

	localparam abus_t CART_LOAD_BASE = 24'h80_0000; // Cart window in console space

	// BEQ after the cart checksum, patched to BRA
	localparam bios_addr_t PATCH_ADDR   = 17'h0136E;
	localparam bios_data_t PATCH_OPCODE = 8'h60;

	// ====================
	// States
	// ====================
	typedef enum logic [1:0] {
		RD_IDLE,  // No cart read pending
		RD_ISSUE, // Request held until ack
		RD_WAIT   // Waiting for DDR data
	} rd_state_e;

	typedef enum logic [1:0] {
		GNT_NONE,
		GNT_LOADER,
		GNT_READER
	} grant_e;

endpackage

//--- src/jag_mem_top.sv
module jag_mem_top #(
	parameter logic [7:0] DDR_REGION = 8'h30
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	// Host download
	input  logic                      ioctl_download,
	input  logic                      ioctl_wr,
	input  jag_mem_pkg::ioctl_index_t ioctl_index,
	input  jag_mem_pkg::ioctl_addr_t  ioctl_addr,
	input  jag_mem_pkg::ioctl_data_t  ioctl_data,
	output logic                      ioctl_wait,
	// Console bus
	input  jag_mem_pkg::abus_t        abus,
	input  logic                      cart_ce_n,
	output jag_mem_pkg::cart_data_t   cart_q,
	output logic                      cart_wait_n,
	input  logic                      checksum_patch,
	output jag_mem_pkg::bios_data_t   bios_q,
	// DDR port
	input  logic                      ddr_busy,
	output jag_mem_pkg::ddr_addr_t    ddr_addr,
	output jag_mem_pkg::ddr_data_t    ddr_din,
	output jag_mem_pkg::ddr_be_t      ddr_be,
	output logic                      ddr_rd,
	output logic                      ddr_we,
	input  jag_mem_pkg::ddr_data_t    ddr_dout,
	input  logic                      ddr_dout_ready
);

	logic loading; // Cart download in progress

	ddr_req_if loader_if ();
	ddr_req_if reader_if ();

	cart_loader u_loader (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_data     (ioctl_data),
		.ioctl_wait     (ioctl_wait),
		.loading        (loading),
		.req_bus        (loader_if.requester)
	);

	cart_reader u_reader (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.abus           (abus),
		.cart_ce_n      (cart_ce_n),
		.ddr_dout       (ddr_dout),
		.ddr_dout_ready (ddr_dout_ready),
		.cart_q         (cart_q),
		.cart_wait_n    (cart_wait_n),
		.req_bus        (reader_if.requester)
	);

	// Loader and reader share the single DDR port
	ddr_arbiter #(
		.DDR_REGION (DDR_REGION)
	) u_arbiter (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.loading    (loading),
		.ddr_busy   (ddr_busy),
		.loader_bus (loader_if.arbiter),
		.reader_bus (reader_if.arbiter),
		.ddr_addr   (ddr_addr),
		.ddr_din    (ddr_din),
		.ddr_be     (ddr_be),
		.ddr_rd     (ddr_rd),
		.ddr_we     (ddr_we)
	);

	bios_store u_bios (
		.clk_sys        (clk_sys),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.abus           (abus),
		.checksum_patch (checksum_patch),
		.bios_q         (bios_q)
	);

endmodule
